//--- logic/board_pkg.sv
package board_pkg;

    //----------------------------
    // Board constants
    //----------------------------

    localparam int n_digits = 8;                // TM1638 digits, one LED per digit

    //----------------------------
    // Datapath records
    //----------------------------

    typedef struct packed
    {
        logic               valid;              // One cycle per received sample
        logic signed [23:0] value;
    } mic_sample_t;

    typedef struct packed
    {
        logic [n_digits - 1:0][7:0] segs;       // abcdefgh, bit 0 = a
        logic [n_digits - 1:0]      leds;
    } meter_display_t;

    typedef struct packed
    {
        logic sio_clk;
        logic sio_stb;                          // Low for one command group
        logic sio_data_out;
        logic sio_data_oe;                      // Pad driver enable
    } tm_pins_t;

    //----------------------------
    // TM1638 controller
    //----------------------------

    typedef enum logic [2:0]
    {
        st_idle,
        st_send_byte,
        st_read_byte,
        st_stb_gap
    } tm_state_t;

    typedef enum logic [7:0]
    {
        cmd_write_auto = 8'h40,                 // Data write, address auto increment
        cmd_read_keys  = 8'h42,
        cmd_addr0      = 8'hc0,
        cmd_display_on = 8'h8f                  // Display on, full brightness
    } tm_cmd_t;

endpackage

//--- logic/slow_strobe_gen.sv
`timescale 1ns/10ps

module slow_strobe_gen
#(
    parameter int clk_mhz    = 27,
    parameter int refresh_hz = 10
)
(
    input  logic clk,
    input  logic reset,
    output logic refresh_tick
);

    localparam int period = clk_mhz * 1_000_000 / refresh_hz;
    localparam int w_cnt  = period > 1 ? $clog2(period) : 1;

    logic [w_cnt - 1:0] cnt;                   // Cycles left in this period

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cnt          <= w_cnt'(period - 1);
            refresh_tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt          <= w_cnt'(period - 1);
            refresh_tick <= 1'b1;
        end
        else
        begin
            cnt          <= cnt - 1'b1;
            refresh_tick <= 1'b0;
        end
    end

endmodule

//--- logic/inmp441_mic_i2s_receiver.sv
`timescale 1ns/10ps

module inmp441_mic_i2s_receiver
#(
    parameter int sck_div = 5
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   sd,
    output logic                   sck,
    output logic                   ws,
    output board_pkg::mic_sample_t mic_sample
);

    localparam int w_div = sck_div > 1 ? $clog2(sck_div) : 1;

    logic [w_div - 1:0] div_cnt;
    logic               sck_edge;              // sck toggles at this clock
    logic [5:0]         bit_cnt;               // Position in the 64 bit stereo frame
    logic [5:0]         bit_next;
    logic [22:0]        shift_reg;
    logic               sample_valid;
    logic [23:0]        sample_value;

    assign sck_edge = (div_cnt == w_div'(sck_div - 1));
    assign bit_next = bit_cnt + 6'd1;

    //----------------------------
    // Serial clock and word select
    //----------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div_cnt      <= '0;
            sck          <= 1'b0;
            ws           <= 1'b0;
            bit_cnt      <= '0;
            sample_valid <= 1'b0;
        end
        else
        begin
            div_cnt      <= sck_edge ? '0 : div_cnt + 1'b1;
            sample_valid <= 1'b0;

            if (sck_edge)
            begin
                sck <= ~sck;

                if (sck)                       // Falling edge starts the next bit
                begin
                    bit_cnt <= bit_next;
                    ws      <= bit_next[5];
                end
                else if (bit_cnt == 6'd24)     // Last data bit of the left slot
                    sample_valid <= 1'b1;
            end
        end
    end

    //----------------------------
    // Data capture on rising sck
    //----------------------------

    always_ff @(posedge clk)
    begin
        if (sck_edge && !sck && bit_cnt >= 6'd1 && bit_cnt <= 6'd24)
        begin
            shift_reg <= {shift_reg[21:0], sd};  // MSB first

            if (bit_cnt == 6'd24)
                sample_value <= {shift_reg, sd};
        end
    end

    assign mic_sample.valid = sample_valid;
    assign mic_sample.value = sample_value;

endmodule

//--- logic/mic_level_meter.sv
`timescale 1ns/10ps

module mic_level_meter
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      refresh_tick,
    input  board_pkg::mic_sample_t    mic_sample,
    input  logic [7:0]                keys,
    output board_pkg::meter_display_t display
);

    logic [23:0] abs_value;
    logic [22:0] magnitude;                    // Saturated at 7FFFFFh
    logic [22:0] peak;
    logic [22:0] peak_next;
    logic        key_clear_q;
    logic        clear_pulse;                  // Rising edge of key 7

    //----------------------------
    // Encoding
    //----------------------------

    function automatic logic [7:0] hex_to_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0:    hex_to_seg = 8'h3f;
            4'h1:    hex_to_seg = 8'h06;
            4'h2:    hex_to_seg = 8'h5b;
            4'h3:    hex_to_seg = 8'h4f;
            4'h4:    hex_to_seg = 8'h66;
            4'h5:    hex_to_seg = 8'h6d;
            4'h6:    hex_to_seg = 8'h7d;
            4'h7:    hex_to_seg = 8'h07;
            4'h8:    hex_to_seg = 8'h7f;
            4'h9:    hex_to_seg = 8'h6f;
            4'ha:    hex_to_seg = 8'h77;
            4'hb:    hex_to_seg = 8'h7c;
            4'hc:    hex_to_seg = 8'h39;
            4'hd:    hex_to_seg = 8'h5e;
            4'he:    hex_to_seg = 8'h79;
            default: hex_to_seg = 8'h71;       // F
        endcase
    endfunction

    // Digit 0 holds the least significant nibble
    function automatic board_pkg::meter_display_t encode_display(input logic [22:0] level_value);
        board_pkg::meter_display_t d;
        logic [23:0]               hex_value;
        logic [4:0]                level;

        hex_value = {1'b0, level_value};
        level     = '0;

        for (int b = 0; b < 23; b++)
            if (level_value[b])
                level = 5'(b + 1);             // Highest set bit plus one

        for (int i = 0; i < 6; i++)
            d.segs[i] = hex_to_seg(hex_value[4 * i +: 4]);

        for (int i = 6; i < board_pkg::n_digits; i++)
            d.segs[i] = 8'h00;                 // Blank

        for (int i = 0; i < board_pkg::n_digits; i++)
            d.leds[i] = (level >= 5'(16 + i));

        return d;
    endfunction

    //----------------------------
    // Magnitude and peak
    //----------------------------

    always_comb
    begin
        abs_value = mic_sample.value[23] ? 24'(-mic_sample.value) : mic_sample.value;
        magnitude = abs_value[23] ? 23'h7f_ffff : abs_value[22:0];
        peak_next = (mic_sample.valid && magnitude > peak) ? magnitude : peak;
    end

    assign clear_pulse = keys[7] & ~key_clear_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            peak        <= '0;
            key_clear_q <= 1'b0;
            display     <= encode_display(23'd0);
        end
        else
        begin
            key_clear_q <= keys[7];

            if (clear_pulse)
            begin
                peak    <= '0;
                display <= encode_display(23'd0);
            end
            else if (refresh_tick)
            begin
                if (!keys[0])                  // Key 0 freezes the display
                    display <= encode_display(peak_next);

                peak <= '0;                    // New refresh window
            end
            else
                peak <= peak_next;
        end
    end

endmodule

//--- logic/tm1638_board_controller.sv
`timescale 1ns/10ps

module tm1638_board_controller
#(
    parameter int tm_clk_div = 20
)
(
    input  logic                      clk,
    input  logic                      reset,
    input  board_pkg::meter_display_t display,
    input  logic                      sio_data_in,
    output board_pkg::tm_pins_t       tm_pins,
    output logic [7:0]                keys
);

    localparam int         w_div          = tm_clk_div > 1 ? $clog2(tm_clk_div) : 1;
    localparam logic [4:0] last_disp_byte = 5'(2 * board_pkg::n_digits);
    localparam logic [4:0] last_read_byte = 5'd4;

    board_pkg::tm_state_t      state;
    board_pkg::meter_display_t disp_q;         // Snapshot for the current frame
    logic [w_div - 1:0]        div_cnt;
    logic                      phase_tick;     // One sio_clk half period elapsed
    logic                      half;           // Next tick raises sio_clk
    logic [1:0]                grp;            // Command group within the frame
    logic [4:0]                byte_cnt;
    logic [4:0]                byte_next;
    logic [4:0]                grp_last;
    logic [1:0]                read_idx;
    logic [2:0]                bit_cnt;
    logic [7:0]                cur_byte;
    logic [7:0]                key_acc;

    // Byte n of group g; group 1 alternates segment byte and LED byte
    function automatic logic [7:0] frame_byte
    (
        input logic [1:0]                g,
        input logic [4:0]                n,
        input board_pkg::meter_display_t d
    );
        logic [4:0] slot;

        slot = n - 5'd1;

        case (g)
            2'd0:    frame_byte = board_pkg::cmd_write_auto;
            2'd2:    frame_byte = board_pkg::cmd_display_on;
            2'd3:    frame_byte = board_pkg::cmd_read_keys;
            default:
                if (n == 5'd0)
                    frame_byte = board_pkg::cmd_addr0;
                else if (slot[0])
                    frame_byte = {7'd0, d.leds[slot[3:1]]};
                else
                    frame_byte = d.segs[slot[3:1]];
        endcase
    endfunction

    assign phase_tick = (div_cnt == w_div'(tm_clk_div - 1));
    assign byte_next  = byte_cnt + 5'd1;
    assign grp_last   = (grp == 2'd1) ? last_disp_byte : 5'd0;
    assign read_idx   = 2'(byte_cnt - 5'd1);   // Read bytes are numbered from 1

    //----------------------------
    // Frame sequencer
    //----------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= board_pkg::st_idle;
            div_cnt  <= '0;
            half     <= 1'b0;
            grp      <= 2'd0;
            byte_cnt <= '0;
            bit_cnt  <= '0;
            keys     <= '0;
            tm_pins  <= '{sio_clk: 1'b1, sio_stb: 1'b1, sio_data_out: 1'b0, sio_data_oe: 1'b0};
        end
        else
        begin
            div_cnt <= phase_tick ? '0 : div_cnt + 1'b1;

            if (phase_tick)
            begin
                case (state)
                    board_pkg::st_idle:
                    begin
                        tm_pins.sio_stb     <= 1'b0;
                        tm_pins.sio_data_oe <= 1'b1;
                        byte_cnt            <= '0;
                        bit_cnt             <= '0;
                        half                <= 1'b0;
                        state               <= board_pkg::st_send_byte;
                    end

                    board_pkg::st_send_byte, board_pkg::st_read_byte:
                    begin
                        if (!half)
                        begin
                            tm_pins.sio_clk <= 1'b0;
                            half            <= 1'b1;

                            if (state == board_pkg::st_send_byte)
                                tm_pins.sio_data_out <= cur_byte[bit_cnt];  // LSB first
                        end
                        else
                        begin
                            tm_pins.sio_clk <= 1'b1;   // Device samples here
                            half            <= 1'b0;
                            bit_cnt         <= bit_cnt + 3'd1;

                            if (bit_cnt == 3'd7)
                            begin
                                if (state == board_pkg::st_read_byte)
                                begin
                                    if (byte_cnt == last_read_byte)
                                    begin
                                        keys  <= key_acc;
                                        state <= board_pkg::st_stb_gap;
                                    end
                                    else
                                        byte_cnt <= byte_next;
                                end
                                else if (grp == 2'd3)
                                begin
                                    tm_pins.sio_data_oe <= 1'b0;  // TM1638 drives data
                                    byte_cnt            <= 5'd1;
                                    state               <= board_pkg::st_read_byte;
                                end
                                else if (byte_cnt == grp_last)
                                    state <= board_pkg::st_stb_gap;
                                else
                                    byte_cnt <= byte_next;
                            end
                        end
                    end

                    board_pkg::st_stb_gap:
                    begin
                        if (!tm_pins.sio_stb)
                        begin
                            tm_pins.sio_stb     <= 1'b1;
                            tm_pins.sio_data_oe <= 1'b0;
                        end
                        else
                        begin
                            grp   <= grp + 2'd1;       // Wraps to the next frame
                            state <= board_pkg::st_idle;
                        end
                    end

                    default:
                        state <= board_pkg::st_idle;
                endcase
            end
        end
    end

    //----------------------------
    // Byte load and key capture
    //----------------------------

    always_ff @(posedge clk)
    begin
        if (phase_tick)
        begin
            if (state == board_pkg::st_idle)
            begin
                cur_byte <= frame_byte(grp, 5'd0, disp_q);

                if (grp == 2'd0)
                    disp_q <= display;         // Frame start
            end
            else if (state == board_pkg::st_send_byte && half && bit_cnt == 3'd7)
                cur_byte <= frame_byte(grp, byte_next, disp_q);

            if (state == board_pkg::st_read_byte && half)
            begin
                if (bit_cnt == 3'd0)
                    key_acc[{1'b0, read_idx}] <= sio_data_in;
                else if (bit_cnt == 3'd4)
                    key_acc[{1'b1, read_idx}] <= sio_data_in;
            end
        end
    end

endmodule

//--- logic/board_specific_top.sv
`timescale 1ns/10ps

module board_specific_top
#(
    parameter int clk_mhz    = 27,
    parameter int refresh_hz = 10,
    parameter int sck_div    = 5,              // 2.7 MHz sck at 27 MHz
    parameter int tm_clk_div = 20              // Keeps sio_clk under 1 MHz
)
(
    input  logic                clk,
    input  logic                reset,

    input  logic                sio_data_in,
    output board_pkg::tm_pins_t tm_pins,

    input  logic                mic_sd,
    output logic                mic_sck,
    output logic                mic_ws,
    output logic                mic_lr
);

    logic                      refresh_tick;
    board_pkg::mic_sample_t    mic_sample;
    board_pkg::meter_display_t display;
    logic [7:0]                keys;

    //----------------------------

    slow_strobe_gen
    #(
        .clk_mhz    ( clk_mhz    ),
        .refresh_hz ( refresh_hz )
    )
    i_strobe
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .refresh_tick ( refresh_tick )
    );

    //----------------------------

    inmp441_mic_i2s_receiver
    #(
        .sck_div ( sck_div )
    )
    i_microphone
    (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .sd         ( mic_sd     ),
        .sck        ( mic_sck    ),
        .ws         ( mic_ws     ),
        .mic_sample ( mic_sample )
    );

    assign mic_lr = 1'b0;                      // Left channel

    //----------------------------

    mic_level_meter i_meter
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .refresh_tick ( refresh_tick ),
        .mic_sample   ( mic_sample   ),
        .keys         ( keys         ),
        .display      ( display      )
    );

    //----------------------------

    tm1638_board_controller
    #(
        .tm_clk_div ( tm_clk_div )
    )
    i_tm1638
    (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .display     ( display     ),
        .sio_data_in ( sio_data_in ),
        .tm_pins     ( tm_pins     ),
        .keys        ( keys        )
    );

endmodule

//--- verification/board_chk.sv
`timescale 1ns/10ps

module board_chk
#(
    parameter int min_gap = 256                // Clocks in 64 sck periods
)
(
    input logic                   clk,
    input logic                   reset,
    input board_pkg::tm_pins_t    tm_pins,
    input board_pkg::mic_sample_t mic_sample
);

    int gap_cnt;                               // Clocks since the last sample

    always_ff @(posedge clk)
    begin
        if (reset)
            gap_cnt <= min_gap;
        else if (mic_sample.valid)
            gap_cnt <= 0;
        else if (gap_cnt < min_gap)
            gap_cnt <= gap_cnt + 1;
    end

    //----------------------------
    // TM1638 pins
    //----------------------------

    oe_inside_strobe: assert property (@(posedge clk) disable iff (reset)
        !(tm_pins.sio_data_oe && tm_pins.sio_stb))
        else $error("sio_data_oe is high while sio_stb is high");

    stb_with_clk_high: assert property (@(posedge clk) disable iff (reset)
        $changed(tm_pins.sio_stb) |-> tm_pins.sio_clk)
        else $error("sio_stb changed while sio_clk was low");

    //----------------------------
    // Receiver
    //----------------------------

    sample_spacing: assert property (@(posedge clk) disable iff (reset)
        mic_sample.valid |-> gap_cnt >= min_gap - 1)
        else $error("mic_sample.valid pulsed twice within 64 sck periods");

endmodule

bind board_specific_top board_chk
#(
    .min_gap ( 128 * sck_div )
)
board_chk_inst
(
    .clk        ( clk        ),
    .reset      ( reset      ),
    .tm_pins    ( tm_pins    ),
    .mic_sample ( mic_sample )
);

//--- verification/board_monitor.sv
`timescale 1ns/10ps

module board_monitor
(
    input  logic                      clk,
    input  logic                      reset,
    input  board_pkg::tm_pins_t       tm_pins,
    input  logic                      mic_sck,
    input  logic                      mic_ws,
    input  logic                      mic_lr,
    input  logic                      frame_valid,     // One decoded TM1638 frame
    input  logic                      frame_fmt_ok,
    input  board_pkg::meter_display_t frame_disp,
    input  logic                      check_en,
    input  int                        test_id,
    input  logic signed [23:0]        exp_amp,
    output int                        error_count,
    output int                        check_count
);

    logic                      reset_q;
    board_pkg::meter_display_t exp_disp;

    function automatic string test_name(input int id);
        case (id)
            1:       test_name = "freeze";
            2:       test_name = "clear";
            default: test_name = "peak_display";
        endcase
    endfunction

    // Segments abcdefgh, bit 0 = a
    function automatic logic [7:0] seven_seg(input logic [3:0] h);
        logic [7:0] table_seg [0:15];
        table_seg = '{8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
                      8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71};
        return table_seg[h];
    endfunction

    //----------------------------
    // Reference model
    //----------------------------

    function automatic board_pkg::meter_display_t expected_display(input logic signed [23:0] a);
        board_pkg::meter_display_t d;
        logic [23:0]               mag;
        int                        level;
        mag   = (a < 0) ? 24'(-a) : 24'(a);
        if (mag[23])
            mag = 24'h7f_ffff;                 // Only -800000h lands here
        level = 0;
        for (int b = 0; b < 23; b++)
            if (mag[b])
                level = b + 1;
        for (int i = 0; i < 8; i++)
        begin
            d.segs[i] = (i < 6) ? seven_seg(mag[4 * i +: 4]) : 8'h00;
            d.leds[i] = (level >= 16 + i);
        end
        return d;
    endfunction

    always @(posedge clk)
    begin
        reset_q <= reset;

        if (reset_q && {tm_pins.sio_stb, tm_pins.sio_clk, tm_pins.sio_data_oe,
            mic_sck, mic_ws} != 5'b11000)
        begin
            $display("MISMATCH after_reset expected %b actual %b", 5'b11000,
                {tm_pins.sio_stb, tm_pins.sio_clk, tm_pins.sio_data_oe, mic_sck, mic_ws});
            error_count <= error_count + 1;
        end

        if (mic_lr !== 1'b0)                   // Left channel select
        begin
            $display("MISMATCH mic_lr expected %b actual %b", 1'b0, mic_lr);
            error_count <= error_count + 1;
        end

        if (frame_valid && !frame_fmt_ok)
        begin
            $display("ERROR: a TM1638 frame broke the 40h, C0h+16, 8Fh, 42h+4 group order");
            error_count <= error_count + 1;
        end

        if (frame_valid && check_en)
        begin
            exp_disp = expected_display(exp_amp);
            check_count <= check_count + 1;
            if (frame_disp.segs != exp_disp.segs)
            begin
                $display("MISMATCH %s expected %h actual %h", test_name(test_id),
                    exp_disp.segs, frame_disp.segs);
                error_count <= error_count + 1;
            end
            else if (frame_disp.leds != exp_disp.leds)
            begin
                $display("MISMATCH led_bar expected %b actual %b", exp_disp.leds,
                    frame_disp.leds);
                error_count <= error_count + 1;
            end
        end
    end

    initial
    begin
        error_count = 0;
        check_count = 0;
    end

endmodule

//--- verification/board_tb.sv
`timescale 1ns/10ps

module board_tb;

    localparam int frame_timeout = 2000;       // Clocks allowed per TM1638 frame

    logic                      clk;
    logic                      reset;
    logic                      sio_data_in;
    logic                      mic_sd;
    logic                      mic_sck;
    logic                      mic_ws;
    logic                      mic_lr;
    board_pkg::tm_pins_t       tm_pins;

    integer                    seed;
    logic signed [23:0]        amplitude;
    logic signed [23:0]        old_amp;
    logic [7:0]                key_state;      // Keys returned by the TM1638 model
    logic                      check_en;
    int                        test_id;
    logic signed [23:0]        exp_amp;
    int                        error_count;
    int                        check_count;
    int                        timeout_count;

    logic                      mic_sck_q;
    logic                      mic_ws_q;
    logic [5:0]                slot_pos;       // Bit position in the I2S frame
    logic signed [23:0]        slot_amp;
    logic                      sd_next;
    logic                      sio_next;

    board_pkg::tm_pins_t       pins_q;
    logic [1:0]                grp_idx;
    logic [7:0]                grp_bytes [0:16];
    int                        grp_len;
    logic [7:0]                shift_byte;
    int                        bit_idx;
    int                        read_cnt;
    logic                      fmt_ok;
    logic                      frame_valid;
    logic                      frame_fmt_ok;
    board_pkg::meter_display_t frame_disp;

    board_specific_top
    #(
        .clk_mhz    ( 1     ),
        .refresh_hz ( 2000  ),                 // Tick every 500 clocks
        .sck_div    ( 2     ),
        .tm_clk_div ( 2     )
    )
    board_specific_top_inst
    (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .sio_data_in ( sio_data_in ),
        .tm_pins     ( tm_pins     ),
        .mic_sd      ( mic_sd      ),
        .mic_sck     ( mic_sck     ),
        .mic_ws      ( mic_ws      ),
        .mic_lr      ( mic_lr      )
    );

    board_monitor monitor_inst
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .tm_pins      ( tm_pins      ),
        .mic_sck      ( mic_sck      ),
        .mic_ws       ( mic_ws       ),
        .mic_lr       ( mic_lr       ),
        .frame_valid  ( frame_valid  ),
        .frame_fmt_ok ( frame_fmt_ok ),
        .frame_disp   ( frame_disp   ),
        .check_en     ( check_en     ),
        .test_id      ( test_id      ),
        .exp_amp      ( exp_amp      ),
        .error_count  ( error_count  ),
        .check_count  ( check_count  )
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //----------------------------
    // Microphone model
    //----------------------------

    always @(posedge clk)
    begin : mic_model
        logic [5:0] pos;
        mic_sck_q <= mic_sck;
        mic_ws_q  <= mic_ws;
        if (reset)
        begin
            slot_pos <= '0;
            slot_amp <= amplitude;
            sd_next  <= 1'b0;
        end
        else if (mic_sck_q && !mic_sck)        // Falling sck shifts the next bit out
        begin
            pos = (mic_ws_q && !mic_ws) ? 6'd0 : slot_pos + 6'd1;
            slot_pos <= pos;
            if (pos == 6'd0)
                slot_amp <= amplitude;         // New left slot
            sd_next <= (pos >= 6'd1 && pos <= 6'd24) ? slot_amp[24 - pos] : 1'b0;
        end
    end

    //----------------------------
    // TM1638 model
    //----------------------------

    always @(posedge clk)
    begin : tm_model
        logic [7:0] b;
        logic       ok;
        pins_q      <= tm_pins;
        frame_valid <= 1'b0;
        if (reset)
        begin
            grp_idx  <= '0;
            grp_len  <= 0;
            bit_idx  <= 0;
            read_cnt <= 0;
            fmt_ok   <= 1'b1;
            sio_next <= 1'b0;
        end
        else
        begin
            if (pins_q.sio_stb && !tm_pins.sio_stb)
            begin
                grp_len  <= 0;
                bit_idx  <= 0;
                read_cnt <= 0;
            end

            // Written bit taken on rising sio_clk from the low phase values
            if (!pins_q.sio_clk && tm_pins.sio_clk && !pins_q.sio_stb && pins_q.sio_data_oe)
            begin
                b          = shift_byte;
                b[bit_idx] = pins_q.sio_data_out;
                shift_byte <= b;
                if (bit_idx == 7)
                begin
                    if (grp_len < 17)
                        grp_bytes[grp_len] <= b;
                    grp_len <= grp_len + 1;
                    bit_idx <= 0;
                end
                else
                    bit_idx <= bit_idx + 1;
            end

            // Read bit out after falling sio_clk
            if (pins_q.sio_clk && !tm_pins.sio_clk && !tm_pins.sio_stb && !tm_pins.sio_data_oe)
            begin
                if (read_cnt < 32 && read_cnt % 8 == 0)
                    sio_next <= key_state[read_cnt / 8];
                else if (read_cnt < 32 && read_cnt % 8 == 4)
                    sio_next <= key_state[read_cnt / 8 + 4];
                else
                    sio_next <= 1'b0;
                read_cnt <= read_cnt + 1;
            end

            if (!pins_q.sio_stb && tm_pins.sio_stb)  // End of a command group
            begin
                ok = fmt_ok;
                case (grp_idx)
                    2'd0: ok = ok && grp_len == 1 && grp_bytes[0] == 8'h40;
                    2'd1:
                    begin
                        ok = ok && grp_len == 17 && grp_bytes[0] == 8'hc0;
                        for (int i = 0; i < 8; i++)
                        begin
                            frame_disp.segs[i] <= grp_bytes[1 + 2 * i];
                            frame_disp.leds[i] <= grp_bytes[2 + 2 * i][0];
                            ok = ok && grp_bytes[2 + 2 * i][7:1] == 7'd0;
                        end
                    end
                    2'd2: ok = ok && grp_len == 1 && grp_bytes[0] == 8'h8f;
                    default:
                    begin
                        ok = ok && grp_len == 1 && grp_bytes[0] == 8'h42 && read_cnt == 32;
                        frame_fmt_ok <= ok;
                        frame_valid  <= 1'b1;
                        ok = 1'b1;
                    end
                endcase
                fmt_ok  <= ok;
                grp_idx <= grp_idx + 2'd1;
            end
        end
    end

    always @(posedge clk)
    begin
        #1;
        mic_sd      = sd_next;
        sio_data_in = sio_next;
    end

    //----------------------------
    // Sequencing
    //----------------------------

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count,
            timeout_count);
        if (error_count == 0 && timeout_count == 0 && check_count > 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    endtask

    task automatic wait_frames(input int n);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < n && cycles < n * frame_timeout)
        begin
            @(posedge clk);
            cycles++;
            if (frame_valid)
                seen++;
        end
        if (seen < n)
        begin
            $display("TIMEOUT: no complete TM1638 frame arrived within %0d clocks",
                n * frame_timeout);
            timeout_count++;
            finish_run();
        end
    endtask

    function automatic logic signed [23:0] random_amplitude();
        logic [31:0] raw;
        int          shift;
        raw   = $random(seed);
        shift = ($random(seed) & 32'h7fff_ffff) % 20;
        return $signed(raw[23:0]) >>> shift;  // Spread over many levels
    endfunction

    // Settles for three frames after a rising edge then checks one
    task automatic run_peak(input logic signed [23:0] a, input int id);
        #1;
        check_en  = 1'b0;
        amplitude = a;
        wait_frames(3);
        #1;
        exp_amp  = a;
        test_id  = id;
        check_en = 1'b1;
        wait_frames(1);
    endtask

    initial
    begin
        seed          = 32'h9975_9564;
        reset         = 1'b1;
        mic_sd        = 1'b0;
        sio_data_in   = 1'b0;
        amplitude     = '0;
        key_state     = '0;
        check_en      = 1'b0;
        test_id       = 0;
        exp_amp       = '0;
        timeout_count = 0;

        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        @(posedge clk);

        run_peak(24'sh80_0000, 0);             // Saturates to 7FFFFF
        for (int t = 0; t < 8; t++)
            run_peak(random_amplitude(), 0);

        // Key 0 freezes the display at the old amplitude
        old_amp = amplitude;
        #1;
        check_en     = 1'b0;
        key_state[0] = 1'b1;
        wait_frames(2);
        #1 amplitude = old_amp ^ 24'sh3c_3c3c;
        wait_frames(3);
        #1;
        exp_amp  = old_amp;
        test_id  = 1;
        check_en = 1'b1;
        wait_frames(1);

        // Key 7 clears while key 0 still blocks any refresh
        #1;
        check_en     = 1'b0;
        key_state[7] = 1'b1;
        wait_frames(1);
        #1;
        exp_amp  = '0;
        test_id  = 2;
        check_en = 1'b1;
        wait_frames(1);

        #1;
        check_en  = 1'b0;
        key_state = '0;
        @(posedge clk);
        run_peak(random_amplitude(), 0);

        finish_run();
    end

endmodule

//--- tm1638_mic_board.f
logic/board_pkg.sv
logic/slow_strobe_gen.sv
logic/inmp441_mic_i2s_receiver.sv
logic/mic_level_meter.sv
logic/tm1638_board_controller.sv
logic/board_specific_top.sv
verification/board_chk.sv
verification/board_monitor.sv
verification/board_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the board testbench with Verilator
set -e

verilator --binary --timing --assert -j 0 \
    --top-module board_tb \
    -f tm1638_mic_board.f \
    -o board_sim

./obj_dir/board_sim > sim.log
cat sim.log

grep -q "=== PASS ===" sim.log
